//--- Makefile
# Verilator build for the packet buffer

TOOL      = verilator
FLIST     = sources.f
TOP       = buf_tb
RTL_TOP   = buf_top
FLAGS     = --timing --assert
SIM_FLAGS = --binary -j 0
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(TOOL) $(SIM_FLAGS) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sources.f
src/buf_types_pkg.sv
src/mem_test_pkg.sv
src/buf_mem_dp.sv
src/buf_wr_stage.sv
src/buf_rd_stage.sv
src/buf_top.sv
tb/buf_tb.sv

//--- src/buf_mem_dp.sv
//########################################
// dual port buffer memory
// bit write enable, registered read,
// test port takes over when enabled
//########################################
`timescale 1ns/1ps

module buf_mem_dp
   import buf_types_pkg::*;
   import mem_test_pkg::*;
#(
   parameter int  DEPTH = 16,               // number of words
   localparam int AW    = $clog2(DEPTH)     // address width
)
(
   input  logic          clk,
   input  mem_wr_t       mem_wr,            // write port from write stage
   input  logic          rd_en,             // read strobe from read stage
   input  logic [AW-1:0] rd_addr,           // read address
   output logic [DW-1:0] rd_dout,           // one cycle after rd_en
   input  bist_req_t     bist,              // test request
   output bist_rdata_t   bist_rdata         // test read result
);

   logic [DW-1:0]  mem [DEPTH];             // storage array
   logic           wr_en;
   logic [MAW-1:0] wr_addr;
   logic [DW-1:0]  wr_wem;
   logic [DW-1:0]  wr_din;
   logic           rd_sel_en;
   logic [AW-1:0]  rd_sel_addr;
   logic [DW-1:0]  rd_q;                    // registered read word
   logic           bist_rd_q;               // last read was a test read

   //########################################
   // port select, test port wins
   //########################################
   assign wr_en       = bist.en ? bist.we   : mem_wr.en;
   assign wr_addr     = bist.en ? bist.addr : mem_wr.addr;
   assign wr_wem      = bist.en ? bist.wem  : mem_wr.wem;
   assign wr_din      = bist.en ? bist.din  : mem_wr.din;
   assign rd_sel_en   = bist.en ? bist.rd   : rd_en;
   assign rd_sel_addr = bist.en ? bist.addr[AW-1:0] : rd_addr;

   //########################################
   // array
   //########################################
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         // masked bits keep old value
         mem[wr_addr[AW-1:0]] <= (mem[wr_addr[AW-1:0]] & ~wr_wem) | (wr_din & wr_wem);
      end
      if (rd_sel_en)
      begin
         rd_q <= mem[rd_sel_addr];          // read before write on same edge
      end
      bist_rd_q <= bist.en & bist.rd;
   end

   assign rd_dout    = rd_q;
   assign bist_rdata = bist_rd_q ? rd_q : '0; // zero unless a test read returned

   // upper address bits from either source must stay in range
   a_wr_addr_range: assert property (@(posedge clk) wr_en |-> int'(wr_addr) < DEPTH)
      else $error("write address %0d beyond depth %0d", wr_addr, DEPTH);

endmodule

//--- src/buf_rd_stage.sv
//########################################
// buffer read stage
// read pointer, empty, read issue with
// two credits and a two entry out buffer
//########################################
`timescale 1ns/1ps

module buf_rd_stage
   import buf_types_pkg::*;
#(
   parameter int  DEPTH = 16,               // store entries
   localparam int AW    = $clog2(DEPTH)     // address width
)
(
   input  logic          clk,
   input  logic          arst_n,
   input  logic          bist_en,           // test port stall
   input  logic [AW:0]   wr_ptr,            // from write stage
   output logic [AW:0]   rd_ptr,            // to write stage
   output logic          rd_en,             // memory read strobe
   output logic [AW-1:0] rd_addr,           // memory read address
   input  logic [DW-1:0] rd_dout,           // data one cycle after rd_en
   output logic          out_valid,
   output out_beat_t     out_beat,
   input  logic          out_ready
);

   logic      empty;
   logic      issue;                        // read goes out this cycle
   logic      pop;                          // consumer takes a beat
   logic      rd_pend;                      // read data arrives now
   logic [1:0] occ;                         // pending reads plus held beats
   logic [1:0] cnt;                         // held beats
   logic      head;                         // oldest held entry
   logic      tail;                         // next free entry
   out_beat_t obuf [2];                     // output buffer

   //########################################
   // read issue
   //########################################
   assign empty   = (wr_ptr == rd_ptr);
   assign pop     = out_valid & out_ready;
   assign occ     = cnt + {1'b0, rd_pend};
   // credit freed by a pop this cycle counts
   assign issue   = ~empty & ~bist_en & ((occ - {1'b0, pop}) < 2'd2);
   assign rd_en   = issue;
   assign rd_addr = rd_ptr[AW-1:0];

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         rd_ptr  <= '0;
         rd_pend <= 1'b0;
      end
      else
      begin
         rd_pend <= issue;                  // memory read is one cycle
         if (issue)
         begin
            rd_ptr <= rd_ptr + 1'b1;        // slot freed at issue
         end
      end
   end

   //########################################
   // output buffer
   //########################################
   always_ff @(posedge clk)
   begin
      if (rd_pend)
      begin
         obuf[tail].data <= rd_dout;        // capture returned word
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         cnt  <= '0;
         head <= 1'b0;
         tail <= 1'b0;
      end
      else
      begin
         cnt  <= cnt + {1'b0, rd_pend} - {1'b0, pop};
         tail <= tail ^ rd_pend;
         head <= head ^ pop;
      end
   end

   assign out_valid = (cnt != 2'd0);
   assign out_beat  = obuf[head];

   // held beat must not change under back pressure
   a_out_stable: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_beat))
      else $error("out_beat changed while stalled");

endmodule

//--- src/buf_top.sv
//########################################
// packet buffer top level
// write stage, dual port memory and read
// stage on one clock
//########################################
`timescale 1ns/1ps

module buf_top
   import buf_types_pkg::*;
   import mem_test_pkg::*;
#(
   parameter int  DEPTH = 16,               // store entries, power of two
   localparam int AW    = $clog2(DEPTH)     // address width
)
(
   input  logic        clk,
   input  logic        arst_n,
   input  logic        in_valid,
   input  in_beat_t    in_beat,
   output logic        in_ready,
   output logic        out_valid,
   output out_beat_t   out_beat,
   input  logic        out_ready,
   input  bist_req_t   bist,                // test access
   output bist_rdata_t bist_rdata
);

   logic [AW:0]   wr_ptr;                   // write stage to read stage
   logic [AW:0]   rd_ptr;                   // read stage to write stage
   mem_wr_t       mem_wr;
   logic          rd_en;
   logic [AW-1:0] rd_addr;
   logic [DW-1:0] rd_dout;

   buf_wr_stage #(.DEPTH(DEPTH)) buf_wr_stage_inst
   (
      .clk        (clk),
      .arst_n     (arst_n),
      .in_valid   (in_valid),
      .in_beat    (in_beat),
      .in_ready   (in_ready),
      .bist_en    (bist.en),                // stall while tested
      .rd_ptr     (rd_ptr),
      .wr_ptr     (wr_ptr),
      .mem_wr     (mem_wr)
   );

   buf_mem_dp #(.DEPTH(DEPTH)) buf_mem_dp_inst
   (
      .clk        (clk),
      .mem_wr     (mem_wr),
      .rd_en      (rd_en),
      .rd_addr    (rd_addr),
      .rd_dout    (rd_dout),
      .bist       (bist),
      .bist_rdata (bist_rdata)
   );

   buf_rd_stage #(.DEPTH(DEPTH)) buf_rd_stage_inst
   (
      .clk        (clk),
      .arst_n     (arst_n),
      .bist_en    (bist.en),                // no reads while tested
      .wr_ptr     (wr_ptr),
      .rd_ptr     (rd_ptr),
      .rd_en      (rd_en),
      .rd_addr    (rd_addr),
      .rd_dout    (rd_dout),
      .out_valid  (out_valid),
      .out_beat   (out_beat),
      .out_ready  (out_ready)
   );

endmodule

//--- src/buf_types_pkg.sv
//########################################
// packet buffer data path types
// widths and the beat structs shared by
// the write stage, read stage and memory
//########################################

package buf_types_pkg;

   //########################################
   // widths
   //########################################
   localparam int DW  = 32;                 // data width
   localparam int NB  = DW / 8;             // byte lanes
   localparam int MAW = 8;                  // max address width, DEPTH 256

   //########################################
   // beats
   //########################################
   typedef struct packed
   {
      logic [DW-1:0] data;                  // payload
      logic [NB-1:0] keep;                  // per byte lane, 1 = write
   } in_beat_t;

   typedef struct packed
   {
      logic [DW-1:0] data;                  // payload read back
   } out_beat_t;

   //########################################
   // memory write port
   //########################################
   typedef struct packed
   {
      logic           en;                   // write strobe
      logic [MAW-1:0] addr;                 // upper bits zero when DEPTH < 256
      logic [DW-1:0]  wem;                  // per bit write enable
      logic [DW-1:0]  din;                  // write data
   } mem_wr_t;

endpackage

//--- src/buf_wr_stage.sv
//########################################
// buffer write stage
// input handshake, write pointer, full
// flag and keep mask to bit enables
//########################################
`timescale 1ns/1ps

module buf_wr_stage
   import buf_types_pkg::*;
#(
   parameter int  DEPTH = 16,               // store entries
   localparam int AW    = $clog2(DEPTH)     // address width
)
(
   input  logic        clk,
   input  logic        arst_n,
   input  logic        in_valid,            // producer has a beat
   input  in_beat_t    in_beat,             // data plus keep
   output logic        in_ready,            // room and no test access
   input  logic        bist_en,             // test port stall
   input  logic [AW:0] rd_ptr,              // from read stage
   output logic [AW:0] wr_ptr,              // to read stage
   output mem_wr_t     mem_wr               // memory write port
);

   logic          full;
   logic          wr_fire;                  // beat accepted this cycle
   logic [DW-1:0] wem;                      // keep expanded to bits
   logic [AW:0]   occupancy;                // entries in store

   //########################################
   // full and handshake
   //########################################
   // wrap bits differ, index equal
   assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
   assign in_ready = ~full & ~bist_en;
   assign wr_fire  = in_valid & in_ready;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= '0;
      end
      else if (wr_fire)
      begin
         wr_ptr <= wr_ptr + 1'b1;           // wraps with extra msb
      end
   end

   //########################################
   // write port
   //########################################
   always_comb
   begin
      for (int i = 0; i < NB; i++)
      begin
         wem[8*i +: 8] = {8{in_beat.keep[i]}}; // one lane per keep bit
      end
   end

   assign mem_wr.en   = wr_fire;            // same edge as the handshake
   assign mem_wr.addr = MAW'(wr_ptr[AW-1:0]);
   assign mem_wr.wem  = wem;
   assign mem_wr.din  = in_beat.data;

   // occupancy from raw pointers, independent of the full flag
   assign occupancy = wr_ptr - rd_ptr;

   a_no_write_full: assert property (@(posedge clk) disable iff (!arst_n)
      mem_wr.en |-> int'(occupancy) < DEPTH)
      else $error("write with %0d entries stored", occupancy);

endmodule

//--- src/mem_test_pkg.sv
//########################################
// memory test access types
// request struct and read data word
//########################################

package mem_test_pkg;

   import buf_types_pkg::*;

   typedef struct packed
   {
      logic           en;                   // test port owns the memory
      logic           we;                   // test write
      logic           rd;                   // test read
      logic [DW-1:0]  wem;                  // per bit write enable
      logic [MAW-1:0] addr;                 // word address
      logic [DW-1:0]  din;                  // test write data
   } bist_req_t;

   // word returned by a test read
   typedef logic [DW-1:0] bist_rdata_t;

endpackage

//--- tb/buf_tb.sv
//########################################
// packet buffer testbench
// random traffic against a byte lane
// model, fill, test port and latency
//########################################
`timescale 1ns/1ps

module buf_tb
   import buf_types_pkg::*;
   import mem_test_pkg::*;
();

   localparam int DEPTH  = 16;
   localparam int AW     = $clog2(DEPTH);
   localparam int N_FULL = 300;             // beats with all lanes kept
   localparam int N_KEEP = 300;             // beats with random keep
   localparam int N_FILL = DEPTH + 3;       // fill plus one held beat
   localparam int TOTAL  = N_FULL + N_KEEP + N_FILL + 1;
   localparam int LIMIT  = 4 * TOTAL + 200; // cycle budget

   logic          clk;
   logic          arst_n;
   logic          in_valid;
   in_beat_t      in_beat;
   logic          in_ready;
   logic          out_valid;
   out_beat_t     out_beat;
   logic          out_ready;
   bist_req_t     bist;
   bist_rdata_t   bist_rdata;

   logic [31:0]   lcg_state = 32'd10;       // fixed seed
   logic [DW-1:0] model_mem [DEPTH];        // expected store contents
   logic [DW-1:0] exp_q [$];                // beats owed by the DUT
   int            wr_cnt;
   int            rd_cnt;
   int            err_cnt;
   int            chk_cnt;
   int            cycles;
   int            beats_left;               // beats still to offer
   int            offer_lvl;                // offer chance in quarters
   int            ready_lvl;                // out_ready chance in quarters
   bit            full_keep;
   bit            in_taken;                 // handshake at next edge
   string         test_name;

   buf_top #(.DEPTH(DEPTH)) buf_top_inst
   (
      .clk        (clk),
      .arst_n     (arst_n),
      .in_valid   (in_valid),
      .in_beat    (in_beat),
      .in_ready   (in_ready),
      .out_valid  (out_valid),
      .out_beat   (out_beat),
      .out_ready  (out_ready),
      .bist       (bist),
      .bist_rdata (bist_rdata)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;               // 100 ns period
   end

   //########################################
   // helpers
   //########################################
   function automatic logic [31:0] rand_word();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic check(input string name, input logic [DW-1:0] exp_val,
                        input logic [DW-1:0] act_val);
      chk_cnt++;
      if (act_val !== exp_val)
      begin
         err_cnt++;
         $display("FAIL %s: expected %h, actual %h", name, exp_val, act_val);
      end
   endtask

   // merge kept lanes into the model slot
   task automatic accept_beat(input in_beat_t b);
      logic [AW-1:0] slot;
      slot = AW'(wr_cnt);                   // write count mod depth
      for (int i = 0; i < NB; i++)
      begin
         if (b.keep[i])
         begin
            model_mem[slot][8*i +: 8] = b.data[8*i +: 8];
         end
      end
      exp_q.push_back(model_mem[slot]);     // whole word comes back
      wr_cnt++;
   endtask

   task automatic take_beat(input out_beat_t b);
      logic [DW-1:0] exp_data;
      if (exp_q.size() == 0)
      begin
         err_cnt++;
         $display("%s: output beat %h arrived with nothing expected", test_name, b.data);
      end
      else
      begin
         exp_data = exp_q.pop_front();
         check($sformatf("%s beat %0d", test_name, rd_cnt), exp_data, b.data);
      end
      rd_cnt++;
   endtask

   // drive at falling edge, sample what the next rising edge transfers
   task automatic run_cycle();
      logic [31:0] r;
      @(negedge clk);
      r = rand_word();
      if (!in_valid || in_taken)
      begin
         in_valid = 1'b0;                   // held beat only drops once taken
         if (beats_left > 0 && int'(r[17:16]) < offer_lvl)
         begin
            in_valid     = 1'b1;
            in_beat.data = rand_word();
            in_beat.keep = full_keep ? '1 : r[27:24];
            beats_left--;
         end
      end
      out_ready = int'(r[21:20]) < ready_lvl;
      #1;
      in_taken = in_valid & in_ready;
      if (in_taken)
      begin
         accept_beat(in_beat);
      end
      if (out_valid && out_ready)
      begin
         take_beat(out_beat);
      end
   endtask

   task automatic drain();
      beats_left = 0;
      ready_lvl  = 4;                       // consumer always ready
      while (exp_q.size() != 0 || in_valid)
      begin
         run_cycle();
      end
      @(negedge clk);
      #1;
      check({test_name, " idle"}, '0, 32'(out_valid));
   endtask

   task automatic traffic(input string name, input int n, input bit keep_all);
      test_name  = name;
      full_keep  = keep_all;
      beats_left = n;
      offer_lvl  = 3;
      ready_lvl  = 3;
      while (beats_left > 0)
      begin
         run_cycle();
      end
      drain();
   endtask

   //########################################
   // directed tests
   //########################################
   task automatic bist_access();
      logic [DW-1:0] word;
      logic [31:0]   r;
      logic [AW-1:0] addr;
      test_name = "test port";
      word      = rand_word();
      r         = rand_word();
      addr      = AW'(r >> 28);
      @(negedge clk);
      bist.en   = 1'b1;
      bist.we   = 1'b1;
      bist.wem  = '1;
      bist.addr = MAW'(addr);
      bist.din  = word;
      #1;
      check("test port in_ready", '0, 32'(in_ready));
      @(negedge clk);
      bist.we = 1'b0;                       // read back same address
      bist.rd = 1'b1;
      @(negedge clk);
      bist.rd = 1'b0;
      #1;
      check("test port read", word, bist_rdata);
      @(negedge clk);
      bist = '0;
      model_mem[addr] = word;               // later passes see the new word
   endtask

   task automatic fill_test();
      int            start;
      int            n;
      logic [DW-1:0] held;
      test_name  = "fill";
      full_keep  = 1'b0;
      beats_left = N_FILL;
      offer_lvl  = 4;
      ready_lvl  = 0;                       // consumer stalled
      start      = wr_cnt;
      n          = 0;
      run_cycle();
      while (in_ready && n < 2 * DEPTH)
      begin
         run_cycle();
         n++;
      end
      check("fill count", DEPTH + 2, wr_cnt - start); // store plus two in flight
      held = exp_q[0];                      // oldest owed beat waits at the output
      check("fill out_valid", 1, 32'(out_valid));
      repeat (4)
      begin
         run_cycle();
         check("fill out_valid held", 1, 32'(out_valid));
         check("fill out_beat held", held, out_beat.data);
      end
      drain();
   endtask

   task automatic latency_test();
      int n;
      int edges;
      test_name  = "latency";
      beats_left = 1;
      offer_lvl  = 4;
      ready_lvl  = 4;
      n          = 0;
      run_cycle();
      while (!in_taken && n < 10)
      begin
         run_cycle();
         n++;
      end
      edges = 0;
      run_cycle();                          // first sample after handshake edge
      while (!out_valid && edges < 10)
      begin
         edges++;
         run_cycle();
      end
      check("latency edges", 2, edges);
      drain();
   endtask

   //########################################
   // sequence
   //########################################
   initial
   begin
      arst_n    = 1'b0;
      in_valid  = 1'b0;
      in_beat   = '0;
      out_ready = 1'b0;
      bist      = '0;
      wr_cnt    = 0;
      rd_cnt    = 0;
      err_cnt   = 0;
      chk_cnt   = 0;
      in_taken  = 1'b0;
      full_keep = 1'b1;
      test_name = "reset";
      repeat (8) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      #1;
      check("reset out_valid", '0, 32'(out_valid));
      check("reset in_ready", 1, 32'(in_ready));
      check("reset bist_rdata", '0, bist_rdata);

      traffic("full keep", N_FULL, 1'b1);   // also fills every slot
      bist_access();
      traffic("random keep", N_KEEP, 1'b0);
      fill_test();
      latency_test();
      check("beats out", wr_cnt, rd_cnt);

      $display("checks %0d, errors %0d, beats in %0d, beats out %0d",
               chk_cnt, err_cnt, wr_cnt, rd_cnt);
      if (err_cnt == 0)
      begin
         $display("PASS: all tests");
      end
      else
      begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   // run limit
   initial
   begin
      cycles = 0;
      while (cycles <= LIMIT)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule
